//--- src/cache_pkg.sv
// ==============================
// Geometry for a 16-bit byte address split as tag, set, word, byte
// REQ_CREDITS must be a power of two
// ==============================
`default_nettype none

package cache_pkg;

    // ==============================
    // Geometry
    // ==============================
    localparam int ADDR_WIDTH      = 16;
    localparam int WORD_WIDTH      = 32;
    localparam int WORDS_PER_LINE  = 4;
    localparam int SET_WIDTH       = 4;
    localparam int TAG_WIDTH       = 8;
    // Line address is tag and set together
    localparam int LINE_ADDR_WIDTH = TAG_WIDTH + SET_WIDTH;
    localparam int REG_ID_WIDTH    = 5;

    // Flow control and far memory timing
    localparam int REQ_CREDITS     = 4;
    localparam int FILL_LATENCY    = 3;

    // Derived values
    localparam int BYTE_SEL_WIDTH  = 2;
    localparam int WORD_SEL_WIDTH  = $clog2(WORDS_PER_LINE);
    localparam int NUM_SETS        = 2 ** SET_WIDTH;
    localparam int NUM_LINES       = 2 ** LINE_ADDR_WIDTH;
    localparam int FIFO_PTR_WIDTH  = $clog2(REQ_CREDITS);

    // ==============================
    // Types
    // ==============================
    typedef enum logic {
        RD_OP = 1'b0,
        WR_OP = 1'b1
    } t_opcode;

    typedef logic [WORD_WIDTH-1:0] t_word;

    // Word 0 sits in the low bits
    typedef logic [WORDS_PER_LINE*WORD_WIDTH-1:0] t_line;

    // Core request
    typedef struct packed {
        t_opcode                 opcode;
        logic [ADDR_WIDTH-1:0]   address;
        t_word                   data;
        logic [REG_ID_WIDTH-1:0] reg_id;
    } t_req;

    // Read response
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]   address;
        t_word                   data;
        logic [REG_ID_WIDTH-1:0] reg_id;
    } t_rsp;

endpackage

`default_nettype wire

//--- src/cache_req_if.sv
// ==============================
// One request per valid/ready handshake
// ==============================
`timescale 1ns/1ps
`default_nettype none

interface cache_req_if;
    import cache_pkg::*;

    // Handshake
    logic                    valid;
    logic                    ready;

    // Request fields
    t_opcode                 opcode;
    logic [ADDR_WIDTH-1:0]   address;
    t_word                   data;
    logic [REG_ID_WIDTH-1:0] reg_id;

    // Buffer side
    modport src (
        output valid, opcode, address, data, reg_id,
        input  ready
    );

    // Controller side
    modport sink (
        input  valid, opcode, address, data, reg_id,
        output ready
    );

endinterface

`default_nettype wire

//--- src/req_buffer.sv
// ==============================
// Core must push only while holding a credit
// No overflow check inside
// ==============================
`timescale 1ns/1ps
`default_nettype none

module req_buffer (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push,
    input  cache_pkg::t_req   push_req,
    output logic              credit_return,
    cache_req_if.src          out_req
);
    import cache_pkg::*;

    // Storage and pointers with one wrap bit
    t_req                    fifo_mem [REQ_CREDITS];
    logic [FIFO_PTR_WIDTH:0] wr_ptr;
    logic [FIFO_PTR_WIDTH:0] rd_ptr;
    logic                    pop;

    // Head entry on the interface
    assign out_req.valid   = (wr_ptr != rd_ptr);
    assign out_req.opcode  = fifo_mem[rd_ptr[FIFO_PTR_WIDTH-1:0]].opcode;
    assign out_req.address = fifo_mem[rd_ptr[FIFO_PTR_WIDTH-1:0]].address;
    assign out_req.data    = fifo_mem[rd_ptr[FIFO_PTR_WIDTH-1:0]].data;
    assign out_req.reg_id  = fifo_mem[rd_ptr[FIFO_PTR_WIDTH-1:0]].reg_id;

    assign pop = out_req.valid && out_req.ready;

    // ==============================
    // Pointers and credit pulse
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            credit_return <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // One credit back per popped entry
            credit_return <= pop;
        end
    end

    // Entry write
    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr[FIFO_PTR_WIDTH-1:0]] <= push_req;
        end
    end

endmodule

`default_nettype wire

//--- src/cache_ctrl.sv
// ==============================
// One request in flight at a time
// Read hit 1 cycle, read miss FILL_LATENCY+2 cycles after pop
// ==============================
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                                  clk,
    input  logic                                  arst_n,
    cache_req_if.sink                             req,
    // Tag array
    input  logic                                  hit,
    output logic                                  tag_fill,
    output logic [cache_pkg::SET_WIDTH-1:0]       set,
    output logic [cache_pkg::TAG_WIDTH-1:0]       tag,
    // Data array
    output logic [cache_pkg::WORD_SEL_WIDTH-1:0]  word,
    output logic                                  word_wr,
    output cache_pkg::t_word                      word_wdata,
    output logic                                  line_fill,
    input  cache_pkg::t_word                      rd_word,
    // Far memory
    output logic                                  mem_rd,
    output logic                                  mem_wr,
    output logic [cache_pkg::LINE_ADDR_WIDTH-1:0] mem_line_addr,
    output cache_pkg::t_word                      mem_wdata,
    input  logic                                  mem_line_valid,
    input  cache_pkg::t_line                      mem_line,
    // Core response
    output logic                                  rsp_valid,
    output cache_pkg::t_rsp                       rsp
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL_WAIT,
        S_RESPOND
    } t_state;

    t_state state;
    t_req   req_q;
    logic   accept;
    logic   is_rd;
    t_word  fill_word;

    // Ready offered only in idle against a waiting request
    assign req.ready = (state == S_IDLE) && req.valid;
    assign accept    = req.valid && req.ready;
    assign is_rd     = (req_q.opcode == RD_OP);

    // ==============================
    // Address split
    // ==============================
    assign tag  = req_q.address[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign set  = req_q.address[BYTE_SEL_WIDTH+WORD_SEL_WIDTH +: SET_WIDTH];
    assign word = req_q.address[BYTE_SEL_WIDTH +: WORD_SEL_WIDTH];

    assign mem_line_addr = {tag, set};
    assign mem_wdata     = req_q.data;
    assign word_wdata    = req_q.data;

    // Miss read goes out once, from lookup
    assign mem_rd    = (state == S_LOOKUP) && is_rd && !hit;
    // Every write goes through to far memory
    assign mem_wr    = (state == S_LOOKUP) && !is_rd;
    // Cached copy updated only on hit
    assign word_wr   = mem_wr && hit;
    // Line and tag installed together
    assign line_fill = (state == S_FILL_WAIT) && mem_line_valid;
    assign tag_fill  = line_fill;

    // Requested word out of the arriving line
    assign fill_word = mem_line[word*WORD_WIDTH +: WORD_WIDTH];

    // ==============================
    // FSM
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (is_rd && !hit) begin
                        state <= S_FILL_WAIT;
                    end else begin
                        // Hit read answers now, write is done
                        rsp_valid <= is_rd;
                        state     <= S_IDLE;
                    end
                end
                S_FILL_WAIT: begin
                    if (mem_line_valid) begin
                        state <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    rsp_valid <= 1'b1;
                    state     <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Request latch and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.opcode  <= req.opcode;
            req_q.address <= req.address;
            req_q.data    <= req.data;
            req_q.reg_id  <= req.reg_id;
        end
        if ((state == S_LOOKUP) && is_rd) begin
            rsp.address <= req_q.address;
            rsp.reg_id  <= req_q.reg_id;
            rsp.data    <= rd_word;
        end
        // Miss data replaces the stale lookup word
        if (line_fill) begin
            rsp.data <= fill_word;
        end
    end

endmodule

`default_nettype wire

//--- src/tag_array.sv
// ==============================
// All entries invalid after reset
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tag_array (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [cache_pkg::SET_WIDTH-1:0] set,
    input  logic [cache_pkg::TAG_WIDTH-1:0] tag,
    output logic                            hit,
    input  logic                            tag_fill
);
    import cache_pkg::*;

    logic [NUM_SETS-1:0]  valid_q;
    logic [TAG_WIDTH-1:0] tag_mem [NUM_SETS];

    // Same-cycle lookup
    assign hit = valid_q[set] && (tag_mem[set] == tag);

    // Valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (tag_fill) begin
            valid_q[set] <= 1'b1;
        end
    end

    // Tag install on fill
    always_ff @(posedge clk) begin
        if (tag_fill) begin
            tag_mem[set] <= tag;
        end
    end

endmodule

`default_nettype wire

//--- src/data_array.sv
// ==============================
// Line contents undefined until filled
// ==============================
`timescale 1ns/1ps
`default_nettype none

module data_array (
    input  logic                                 clk,
    input  logic [cache_pkg::SET_WIDTH-1:0]      set,
    input  logic [cache_pkg::WORD_SEL_WIDTH-1:0] word,
    input  logic                                 word_wr,
    input  cache_pkg::t_word                     word_wdata,
    input  logic                                 line_fill,
    input  cache_pkg::t_line                     fill_line,
    output cache_pkg::t_word                     rd_word
);
    import cache_pkg::*;

    // One line per set
    t_line lines [NUM_SETS];

    // ==============================
    // Write port
    // ==============================
    always_ff @(posedge clk) begin
        // Whole line from far memory
        if (line_fill) begin
            lines[set] <= fill_line;
        end else if (word_wr) begin
            // Single word merge
            lines[set][word*WORD_WIDTH +: WORD_WIDTH] <= word_wdata;
        end
    end

    // ==============================
    // Read port
    // ==============================
    // Addressed word, combinational
    assign rd_word = lines[set][word*WORD_WIDTH +: WORD_WIDTH];

endmodule

`default_nettype wire

//--- src/far_mem.sv
// ==============================
// Zeroed on reset, one line read outstanding
// ==============================
`timescale 1ns/1ps
`default_nettype none

module far_mem (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  mem_rd,
    input  logic                                  mem_wr,
    input  logic [cache_pkg::LINE_ADDR_WIDTH-1:0] mem_line_addr,
    input  cache_pkg::t_word                      mem_wdata,
    input  logic [cache_pkg::WORD_SEL_WIDTH-1:0]  mem_word,
    output logic                                  mem_line_valid,
    output cache_pkg::t_line                      mem_line
);
    import cache_pkg::*;

    t_line                   mem [NUM_LINES];
    // Read delay line
    logic [FILL_LATENCY-1:0] rd_vld;
    t_line                   rd_pipe [FILL_LATENCY];

    // ==============================
    // Storage
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_wr) begin
            // Word merge into the addressed line
            mem[mem_line_addr][mem_word*WORD_WIDTH +: WORD_WIDTH] <= mem_wdata;
        end
    end

    // ==============================
    // Fixed latency line read
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_vld <= '0;
        end else begin
            rd_vld[0] <= mem_rd;
            for (int s = 1; s < FILL_LATENCY; s++) begin
                rd_vld[s] <= rd_vld[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_rd) begin
            rd_pipe[0] <= mem[mem_line_addr];
        end
        for (int s = 1; s < FILL_LATENCY; s++) begin
            rd_pipe[s] <= rd_pipe[s-1];
        end
    end

    // Last stage out
    assign mem_line_valid = rd_vld[FILL_LATENCY-1];
    assign mem_line       = rd_pipe[FILL_LATENCY-1];

endmodule

`default_nettype wire

//--- src/cache_top.sv
// ==============================
// Core holds REQ_CREDITS credits and always takes a response
// ==============================
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  logic                               clk,
    input  logic                               arst_n,
    // Core request
    input  logic                               req_valid,
    input  cache_pkg::t_opcode                 req_opcode,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]   req_address,
    input  cache_pkg::t_word                   req_data,
    input  logic [cache_pkg::REG_ID_WIDTH-1:0] req_reg_id,
    output logic                               credit_return,
    // Core read response
    output logic                               rsp_valid,
    output logic [cache_pkg::ADDR_WIDTH-1:0]   rsp_address,
    output cache_pkg::t_word                   rsp_data,
    output logic [cache_pkg::REG_ID_WIDTH-1:0] rsp_reg_id
);
    import cache_pkg::*;

    t_req                       push_req;
    t_rsp                       rsp;
    logic                       hit;
    logic                       tag_fill;
    logic [SET_WIDTH-1:0]       set;
    logic [TAG_WIDTH-1:0]       tag;
    logic [WORD_SEL_WIDTH-1:0]  word;
    logic                       word_wr;
    t_word                      word_wdata;
    logic                       line_fill;
    t_word                      rd_word;
    logic                       mem_rd;
    logic                       mem_wr;
    logic [LINE_ADDR_WIDTH-1:0] mem_line_addr;
    t_word                      mem_wdata;
    logic                       mem_line_valid;
    t_line                      mem_line;

    cache_req_if req_if ();

    // Plain ports to and from records
    assign push_req    = '{opcode: req_opcode, address: req_address,
                           data: req_data, reg_id: req_reg_id};
    assign rsp_address = rsp.address;
    assign rsp_data    = rsp.data;
    assign rsp_reg_id  = rsp.reg_id;

    // ==============================
    // Blocks
    // ==============================
    req_buffer u_req_buffer (
        .clk           (clk),
        .arst_n        (arst_n),
        .push          (req_valid),
        .push_req      (push_req),
        .credit_return (credit_return),
        .out_req       (req_if.src)
    );

    cache_ctrl u_cache_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .req            (req_if.sink),
        .hit            (hit),
        .tag_fill       (tag_fill),
        .set            (set),
        .tag            (tag),
        .word           (word),
        .word_wr        (word_wr),
        .word_wdata     (word_wdata),
        .line_fill      (line_fill),
        .rd_word        (rd_word),
        .mem_rd         (mem_rd),
        .mem_wr         (mem_wr),
        .mem_line_addr  (mem_line_addr),
        .mem_wdata      (mem_wdata),
        .mem_line_valid (mem_line_valid),
        .mem_line       (mem_line),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp)
    );

    tag_array u_tag_array (
        .clk      (clk),
        .arst_n   (arst_n),
        .set      (set),
        .tag      (tag),
        .hit      (hit),
        .tag_fill (tag_fill)
    );

    data_array u_data_array (
        .clk        (clk),
        .set        (set),
        .word       (word),
        .word_wr    (word_wr),
        .word_wdata (word_wdata),
        .line_fill  (line_fill),
        .fill_line  (mem_line),
        .rd_word    (rd_word)
    );

    far_mem u_far_mem (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_rd         (mem_rd),
        .mem_wr         (mem_wr),
        .mem_line_addr  (mem_line_addr),
        .mem_wdata      (mem_wdata),
        .mem_word       (word),
        .mem_line_valid (mem_line_valid),
        .mem_line       (mem_line)
    );

endmodule

`default_nettype wire

//--- tb/cache_tb.sv
// ==============================
// Runs from the project root, reads tb/cache_input.txt
// Core side only, far memory seen through the cache
// ==============================
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int MAX_REQS = 64;
    // One miss per buffered entry plus slack
    localparam int DRAIN_LIMIT = REQ_CREDITS * (FILL_LATENCY + 4) + 10;

    logic                    clk;
    logic                    arst_n;
    logic                    req_valid;
    t_opcode                 req_opcode;
    logic [ADDR_WIDTH-1:0]   req_address;
    t_word                   req_data;
    logic [REG_ID_WIDTH-1:0] req_reg_id;
    logic                    credit_return;
    logic                    rsp_valid;
    logic [ADDR_WIDTH-1:0]   rsp_address;
    t_word                   rsp_data;
    logic [REG_ID_WIDTH-1:0] rsp_reg_id;

    // Records of op, address, data, reg_id
    logic [59:0]             stim [MAX_REQS];
    int                      num_reqs;
    int                      sent;
    int                      returned;
    logic                    loaded;
    logic                    started;

    // Expected reads in request order
    logic [ADDR_WIDTH-1:0]   exp_addr [$];
    t_word                   exp_data [$];
    logic [REG_ID_WIDTH-1:0] exp_reg_id [$];

    cache_top u_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req_opcode    (req_opcode),
        .req_address   (req_address),
        .req_data      (req_data),
        .req_reg_id    (req_reg_id),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp_address   (rsp_address),
        .rsp_data      (rsp_data),
        .rsp_reg_id    (rsp_reg_id)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // Failure and compare tasks
    // ==============================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input t_word got, input t_word exp);
        if (got !== exp) begin
            $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
            abort_run("data word mismatch");
        end
    endtask

    task automatic check_address(input string name, input logic [ADDR_WIDTH-1:0] got,
                                 input logic [ADDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
            abort_run("address mismatch");
        end
    endtask

    task automatic check_reg_id(input string name, input logic [REG_ID_WIDTH-1:0] got,
                                input logic [REG_ID_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
            abort_run("reg_id mismatch");
        end
    endtask

    // ==============================
    // Monitor, sampled mid cycle
    // ==============================
    always @(negedge clk) begin
        // Quiet outputs through reset and the idle gap after it
        if (!started && (rsp_valid || credit_return)) begin
            abort_run("rsp_valid or credit_return high during or right after reset");
        end
        if (credit_return) begin
            returned = returned + 1;
        end
        if (rsp_valid) begin
            if (exp_data.size() == 0) begin
                abort_run("read response arrived with no read outstanding");
            end
            check_address("rsp_address", rsp_address, exp_addr.pop_front());
            check_word("rsp_data", rsp_data, exp_data.pop_front());
            check_reg_id("rsp_reg_id", rsp_reg_id, exp_reg_id.pop_front());
        end
    end

    // Per request budget covers a miss plus random gaps
    initial begin
        wait (loaded);
        repeat (num_reqs * (FILL_LATENCY + 6) + 100) @(posedge clk);
        abort_run("Watchdog expired before all requests were answered");
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        int gap;
        int drain;

        void'($urandom(32'h764));
        arst_n      = 1'b1;
        req_valid   = 1'b0;
        req_opcode  = RD_OP;
        req_address = '0;
        req_data    = '0;
        req_reg_id  = '0;
        sent        = 0;
        returned    = 0;
        started     = 1'b0;
        loaded      = 1'b0;

        // Op digit F marks unused slots
        for (int i = 0; i < MAX_REQS; i++) begin
            stim[i] = {4'hF, 56'(i)};
        end
        $readmemh("tb/cache_input.txt", stim);
        num_reqs = 0;
        while ((num_reqs < MAX_REQS) && (stim[num_reqs][59:56] != 4'hF)) begin
            num_reqs = num_reqs + 1;
        end
        if (num_reqs == 0) begin
            abort_run("No requests found in tb/cache_input.txt");
        end
        loaded = 1'b1;

        #5 arst_n = 1'b0;
        repeat (5) @(posedge clk);
        #10 arst_n = 1'b1;
        repeat (2) @(posedge clk);
        #10 started = 1'b1;

        for (int i = 0; i < num_reqs; i++) begin
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge clk);
                #10;
            end
            // Hold off until a credit is back
            while ((sent - returned) >= REQ_CREDITS) begin
                @(posedge clk);
                #10;
            end
            req_valid   = 1'b1;
            req_opcode  = t_opcode'(stim[i][56]);
            req_address = stim[i][55:40];
            req_data    = stim[i][39:8];
            req_reg_id  = stim[i][REG_ID_WIDTH-1:0];
            sent        = sent + 1;
            if (req_opcode == RD_OP) begin
                exp_addr.push_back(req_address);
                exp_data.push_back(req_data);
                exp_reg_id.push_back(req_reg_id);
            end
            @(posedge clk);
            #10 req_valid = 1'b0;
        end

        // Drain within a bound, then look for stray credits
        drain = 0;
        while (((returned != sent) || (exp_data.size() != 0)) && (drain < DRAIN_LIMIT)) begin
            @(posedge clk);
            drain = drain + 1;
        end
        repeat (5) @(posedge clk);
        if ((returned != sent) || (exp_data.size() != 0)) begin
            $display("Credit count not full or reads unanswered at end of run");
            $display("Simulation failed");
            $fatal(1, "end of run check");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
src/cache_pkg.sv
src/cache_req_if.sv
src/req_buffer.sv
src/cache_ctrl.sv
src/tag_array.sv
src/data_array.sv
src/far_mem.sv
src/cache_top.sv
tb/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the cache testbench with Verilator and run it from the project root.
# The exit status is the simulator's own: nonzero on any $fatal.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sources.f --top-module cache_tb \
    && ./obj_dir/Vcache_tb \
    || exit 1

//--- tb/cache_input.txt
// One request per line as op_address_data_regid, all hex
// op 0 is a read with data as the expected word, op 1 is a write
// Never-written address reads zero, then a hit on that zero line
0_1230_00000000_01
0_1234_00000000_02
// Write miss goes to far memory only, then a miss fill and a hit
1_2040_AAAA0001_03
0_2040_AAAA0001_04
0_2040_AAAA0001_05
// Write hit on a cached line, other words unchanged
1_2044_BBBB0002_06
0_2044_BBBB0002_07
0_2040_AAAA0001_08
0_2048_00000000_09
// Tags 0x20 and 0x30 share set 4
1_3040_CCCC0003_0A
0_3040_CCCC0003_0B
0_2044_BBBB0002_0C
0_3040_CCCC0003_0D
1_204C_DDDD0004_0E
0_204C_DDDD0004_0F
0_3044_00000000_10
// Burst of writes then reads in set 7
1_5070_11110001_11
1_5074_22220002_12
1_5078_33330003_13
1_507C_44440004_14
0_507C_44440004_15
0_5078_33330003_16
0_5074_22220002_17
0_5070_11110001_18
